/* common/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Program counter width in bits
`define PC_WIDTH 32

// Issue queue entries
`define QUEUE_DEPTH 4

// First fetch address out of reset
`define RESET_PC 32'h0000_1000

// Trap vector until software writes one
`define TRAP_RESET 32'h0000_0100

`endif

/* common/pipePkg.sv */
`include "pipe_macros.svh"

package pipePkg;

    // ----------------------------------------
    // Address and token types
    // ----------------------------------------

    // Program counter value
    typedef logic [`PC_WIDTH-1:0] addrT;

    // One instruction slot in the pipeline
    typedef struct packed {
        logic valid;
        addrT pc;
    } tokenT;

    // Bubble loaded by a flushed stage
    localparam tokenT NullToken = '{valid: 1'b0, pc: '0};

endpackage

/* common/pipeCtrlIf.sv */
`timescale 1ns/1ps

interface pipeCtrlIf;
    // Front end
    logic stallF;
    logic stallF2;
    logic flushF2;
    logic stallD;
    logic flushD;
    // Issue queue and I stage
    logic stallI;
    logic stallIDe;
    logic flushI;
    logic flushQue;
    // Back end
    logic stallE;
    logic flushE;
    logic stallM;
    logic flushM;
    logic stallM2;
    logic flushM2;
    logic flushW;

    modport hazard (
        output stallF, stallF2, flushF2, stallD, flushD, stallI, stallIDe, flushI,
        output flushQue, stallE, flushE, stallM, flushM, stallM2, flushM2, flushW
    );
    modport fetch (input stallF);
    modport pipe (
        input stallF2, flushF2, stallD, flushD, stallI, stallIDe, flushI, flushQue,
        input stallE, flushE, stallM, flushM, stallM2, flushM2, flushW
    );
endinterface

/* hazard/hazard.sv */
`timescale 1ns/1ps

module hazard (
    input logic clk,
    input logic reset,
    input logic branchM,
    input logic iWait,
    input logic dWait,
    input logic eWait,
    input logic overflowI,
    input logic excpM,
    input logic excpW,
    pipeCtrlIf.hazard ctrl
);

    logic excpIWait;
    logic excpIWaitNxt;
    logic branchIWait;
    logic branchIWaitNxt;
    logic fetchHold;

    // Redirects that landed while fetch was waiting
    always_ff @(posedge clk) begin
        if (reset) begin
            excpIWait <= 1'b0;
            branchIWait <= 1'b0;
        end else begin
            excpIWait <= excpIWaitNxt;
            branchIWait <= branchIWaitNxt;
        end
    end

    // ----------------------------------------
    // Priority: excp, dWait, branch, eWait,
    // overflow, iWait
    // ----------------------------------------
    always_comb begin
        fetchHold = 1'b0;
        ctrl.stallF2 = 1'b0;
        ctrl.flushF2 = 1'b0;
        ctrl.stallD = 1'b0;
        ctrl.flushD = 1'b0;
        ctrl.stallI = 1'b0;
        ctrl.stallIDe = 1'b0;
        ctrl.flushI = 1'b0;
        ctrl.flushQue = 1'b0;
        ctrl.stallE = 1'b0;
        ctrl.flushE = 1'b0;
        ctrl.stallM = 1'b0;
        ctrl.flushM = 1'b0;
        ctrl.stallM2 = 1'b0;
        ctrl.flushM2 = 1'b0;
        ctrl.flushW = 1'b0;
        excpIWaitNxt = excpIWait;
        branchIWaitNxt = branchIWait;

        if (excpM || excpW || branchM && !dWait) begin
            // Kill everything younger than the redirecting stage
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            ctrl.flushQue = 1'b1;
            if (excpW) begin
                ctrl.flushM2 = 1'b1;
                ctrl.flushW = 1'b1;
            end
            if (iWait) begin
                fetchHold = 1'b1;
                if (excpM || excpW) begin
                    excpIWaitNxt = 1'b1;
                end else begin
                    branchIWaitNxt = 1'b1;
                end
            end
        end else if (dWait) begin
            // Memory stall, M2 drains as a bubble
            fetchHold = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallIDe = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.stallM = 1'b1;
            ctrl.flushM2 = 1'b1;
        end else if (eWait) begin
            // Back end holds while the front end fills the queue
            ctrl.stallIDe = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.flushM = 1'b1;
            if (overflowI) begin
                fetchHold = 1'b1;
                ctrl.stallF2 = 1'b1;
                ctrl.stallD = 1'b1;
                ctrl.stallI = 1'b1;
            end else if (iWait) begin
                fetchHold = 1'b1;
                ctrl.flushF2 = 1'b1;
            end
        end else if (overflowI) begin
            // Front end waits while the queue drains
            fetchHold = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
        end else if (iWait) begin
            fetchHold = 1'b1;
            ctrl.flushF2 = 1'b1;
        end

        // Fetch resumes on the new path, drop the stale slot
        if (!fetchHold && (excpIWait || branchIWait)) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            excpIWaitNxt = 1'b0;
            branchIWaitNxt = 1'b0;
        end
    end

    assign ctrl.stallF = fetchHold;

    // Retirement is only cancelled by a W stage exception
    flushWCause: assert property (@(posedge clk) disable iff (reset) ctrl.flushW |-> excpW);

endmodule

/* source/fetchPc.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module fetchPc
    import pipePkg::*;
(
    input logic clk,
    input logic reset,
    pipeCtrlIf.fetch ctrl,
    input logic redirect,
    input addrT redirectPc,
    output tokenT fetchToken
);

    // Sequential step
    localparam addrT PcStep = addrT'(4);

    addrT pc;
    logic pending;

    // ----------------------------------------
    // PC register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
            pending <= 1'b0;
        end else if (redirect) begin
            // Redirect wins over a held fetch
            pc <= redirectPc;
            pending <= ctrl.stallF;
        end else if (!ctrl.stallF) begin
            if (pending) begin
                // Resume cycle is flushed, so issue the target again
                pending <= 1'b0;
            end else begin
                pc <= pc + PcStep;
            end
        end
    end

    always_comb begin
        fetchToken.valid = !ctrl.stallF;
        fetchToken.pc = pc;
    end

endmodule

/* source/trapRegs.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module trapRegs
    import pipePkg::*;
(
    input logic clk,
    input logic reset,
    input logic cfgWrite,
    input addrT cfgVector,
    input logic excpTake,
    input addrT excpPc,
    output addrT trapVector,
    output addrT epc
);

    // Handler entry point
    always_ff @(posedge clk) begin
        if (reset) begin
            trapVector <= `TRAP_RESET;
        end else if (cfgWrite) begin
            trapVector <= cfgVector;
        end
    end

    // PC of the faulting token
    always_ff @(posedge clk) begin
        if (excpTake) begin
            epc <= excpPc;
        end
    end

endmodule

/* source/stageChain.sv */
`timescale 1ns/1ps

module stageChain
    import pipePkg::*;
(
    input logic clk,
    input logic reset,
    pipeCtrlIf.pipe ctrl,
    input tokenT fetchToken,
    input tokenT queueHead,
    output tokenT decodeToken,
    output tokenT mToken,
    output tokenT wToken
);

    tokenT f2Q;
    tokenT dQ;
    tokenT iQ;
    tokenT eQ;
    tokenT mQ;
    tokenT m2Q;
    tokenT wQ;

    // Flush beats stall, stall beats advance
    function automatic tokenT stageNext(
        tokenT cur,
        tokenT prev,
        logic stall,
        logic flush
    );
        tokenT nxt;
        if (flush) begin
            nxt = NullToken;
        end else if (stall) begin
            nxt = cur;
        end else begin
            nxt = prev;
        end
        return nxt;
    endfunction

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            f2Q <= NullToken;
            dQ <= NullToken;
            iQ <= NullToken;
            eQ <= NullToken;
            mQ <= NullToken;
            m2Q <= NullToken;
            wQ <= NullToken;
        end else begin
            // Before the queue
            f2Q <= stageNext(f2Q, fetchToken, ctrl.stallF2, ctrl.flushF2);
            dQ <= stageNext(dQ, f2Q, ctrl.stallD, ctrl.flushD);
            // After the queue, I follows the dequeue side
            iQ <= stageNext(iQ, queueHead, ctrl.stallIDe, ctrl.flushI);
            eQ <= stageNext(eQ, iQ, ctrl.stallE, ctrl.flushE);
            mQ <= stageNext(mQ, eQ, ctrl.stallM, ctrl.flushM);
            m2Q <= stageNext(m2Q, mQ, ctrl.stallM2, ctrl.flushM2);
            wQ <= stageNext(wQ, m2Q, 1'b0, ctrl.flushW);
        end
    end

    assign decodeToken = dQ;
    assign mToken = mQ;
    assign wToken = wQ;

    // A stage is never held and emptied together
    // M2 may still flush behind a held M under dWait
    noStallFlush: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.stallF2 && ctrl.flushF2) && !(ctrl.stallD && ctrl.flushD) &&
        !(ctrl.stallIDe && ctrl.flushI) && !(ctrl.stallE && ctrl.flushE) &&
        !(ctrl.stallM && ctrl.flushM));

endmodule

/* source/issueQueue.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module issueQueue
    import pipePkg::*;
(
    input logic clk,
    input logic reset,
    pipeCtrlIf.pipe ctrl,
    input tokenT pushToken,
    input logic pushEn,
    input logic popEn,
    output tokenT head,
    output logic overflowI
);

    localparam int Depth = `QUEUE_DEPTH;
    localparam int PtrW = $clog2(Depth);
    localparam int CntW = $clog2(Depth + 1);

    tokenT mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic empty;
    logic full;
    logic doPush;

    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == CntW'(Depth));
    // Write port closes while the issue side is held
    assign doPush = pushEn && !ctrl.stallI;

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushToken;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset || ctrl.flushQue) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popEn) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, popEn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = empty ? NullToken : mem[rdPtr];
    // Back-pressure starts one entry short of full
    assign overflowI = (count >= CntW'(Depth - 1));

    // Hazard back-pressure must keep the queue from overrunning
    noPushFull: assert property (@(posedge clk) disable iff (reset) !(doPush && full));
    noPopEmpty: assert property (@(posedge clk) disable iff (reset) !(popEn && empty));

endmodule

/* source/pipeTop.sv */
`timescale 1ns/1ps

module pipeTop
    import pipePkg::*;
(
    input logic clk,
    input logic reset,
    input logic iWait,
    input logic dWait,
    input logic eWait,
    input logic branchM,
    input logic excpM,
    input logic excpW,
    input logic cfgWrite,
    input logic [31:0] branchTarget,
    input logic [31:0] cfgVector,
    output logic [31:0] fetchPc,
    output logic [31:0] retirePc,
    output logic [31:0] mPc,
    output logic [31:0] epc,
    output logic retireValid,
    output logic mValid
);

    pipeCtrlIf ctrlBus ();

    tokenT fetchToken;
    tokenT decodeToken;
    tokenT queueHead;
    tokenT mToken;
    tokenT wToken;
    addrT trapVector;
    addrT redirectPc;
    addrT excpPc;
    logic overflowI;
    logic redirect;
    logic excpTake;
    logic pushEn;
    logic popEn;

    // ----------------------------------------
    // Redirect and trap glue
    // ----------------------------------------
    assign excpTake = excpM || excpW;
    // A branch waits behind dWait like the rest of M
    assign redirect = excpTake || (branchM && !dWait);
    assign redirectPc = excpTake ? trapVector : branchTarget;
    // W is older than M
    assign excpPc = excpW ? wToken.pc : mToken.pc;

    // Queue enqueue from D, dequeue into I
    assign pushEn = decodeToken.valid && !ctrlBus.stallD;
    assign popEn = queueHead.valid && !ctrlBus.stallIDe;

    hazard iHazard (
        .clk(clk), .reset(reset), .branchM(branchM), .iWait(iWait), .dWait(dWait),
        .eWait(eWait), .overflowI(overflowI), .excpM(excpM), .excpW(excpW), .ctrl(ctrlBus)
    );

    fetchPc iFetchPc (
        .clk(clk), .reset(reset), .ctrl(ctrlBus), .redirect(redirect),
        .redirectPc(redirectPc), .fetchToken(fetchToken)
    );

    trapRegs iTrapRegs (
        .clk(clk), .reset(reset), .cfgWrite(cfgWrite), .cfgVector(cfgVector),
        .excpTake(excpTake), .excpPc(excpPc), .trapVector(trapVector), .epc(epc)
    );

    stageChain iStageChain (
        .clk(clk), .reset(reset), .ctrl(ctrlBus), .fetchToken(fetchToken),
        .queueHead(queueHead), .decodeToken(decodeToken), .mToken(mToken), .wToken(wToken)
    );

    issueQueue iIssueQueue (
        .clk(clk), .reset(reset), .ctrl(ctrlBus), .pushToken(decodeToken), .pushEn(pushEn),
        .popEn(popEn), .head(queueHead), .overflowI(overflowI)
    );

    assign fetchPc = fetchToken.pc;
    assign mPc = mToken.pc;
    assign mValid = mToken.valid;
    assign retirePc = wToken.pc;
    assign retireValid = wToken.valid && !ctrlBus.flushW;

endmodule

/* verif/pipeTb.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipeTb
    import pipePkg::*;
();

    // Roughly ten times the length of all tests together
    localparam int TimeoutCycles = 4000;

    logic clk;
    logic reset;
    logic iWait;
    logic dWait;
    logic eWait;
    logic branchM;
    logic excpM;
    logic excpW;
    logic cfgWrite;
    addrT branchTarget;
    addrT cfgVector;
    addrT fetchPc;
    addrT retirePc;
    addrT mPc;
    addrT epc;
    logic retireValid;
    logic mValid;

    // Retirement model
    addrT expectedPc = `RESET_PC;
    int retireCount = 0;
    logic redirectArmed = 1'b0;
    addrT redirectAt;
    addrT redirectTo;
    logic [31:0] lcgState = 32'h2fe4ccdc;
    int cycleCount = 0;

    pipeTop i_pipeTop (
        .clk(clk), .reset(reset), .iWait(iWait), .dWait(dWait), .eWait(eWait),
        .branchM(branchM), .excpM(excpM), .excpW(excpW), .cfgWrite(cfgWrite),
        .branchTarget(branchTarget), .cfgVector(cfgVector), .fetchPc(fetchPc),
        .retirePc(retirePc), .mPc(mPc), .epc(epc), .retireValid(retireValid),
        .mValid(mValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Checks and helpers
    // ----------------------------------------
    task automatic checkAddr(string name, addrT got, addrT exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic checkValid(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lcg();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Next drive point, just after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic waitRetire(int n);
        int target;
        target = retireCount + n;
        while (retireCount < target) begin
            tick();
        end
    endtask

    task automatic waitMValid();
        while (!mValid) begin
            tick();
        end
    endtask

    task automatic writeTrapVector(addrT vector);
        cfgWrite = 1'b1;
        cfgVector = vector;
        tick();
        cfgWrite = 1'b0;
    endtask

    // Retired stream jumps once the older PCs are gone
    task automatic armRedirect(addrT at, addrT to);
        redirectAt = at;
        redirectTo = to;
        redirectArmed = 1'b1;
    endtask

    // Compare every retired PC with the model
    always @(negedge clk) begin
        if (!reset && retireValid) begin
            if (redirectArmed && expectedPc == redirectAt) begin
                expectedPc = redirectTo;
                redirectArmed = 1'b0;
            end
            checkAddr("retirePc", retirePc, expectedPc);
            expectedPc = expectedPc + 32'd4;
            retireCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run did not finish within %0d cycles", TimeoutCycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic sequentialRetire();
        checkAddr("fetchPc", fetchPc, `RESET_PC);
        checkValid("retireValid", retireValid, 1'b0);
        checkValid("mValid", mValid, 1'b0);
        // First token to reach M is the reset fetch
        waitMValid();
        checkAddr("mPc", mPc, `RESET_PC);
        waitRetire(20);
    endtask

    task automatic stallPulses();
        logic [31:0] r;
        int len;
        for (int i = 0; i < 30; i++) begin
            r = lcg();
            len = (r >> 8) % 4 + 1;
            dWait = (r[1:0] != 2'd1);
            eWait = (r[1:0] != 2'd0);
            repeat (len) tick();
            dWait = 1'b0;
            eWait = 1'b0;
            repeat ((r >> 16) % 3) tick();
        end
        waitRetire(10);
    endtask

    task automatic branchInM(addrT target);
        waitMValid();
        // The branch itself retires, younger slots are replaced
        armRedirect(mPc + 32'd4, target);
        branchM = 1'b1;
        branchTarget = target;
        tick();
        branchM = 1'b0;
        checkAddr("fetchPc", fetchPc, target);
        waitRetire(10);
        checkValid("redirectArmed", redirectArmed, 1'b0);
    endtask

    task automatic branchInIWait(addrT target);
        int len;
        len = lcg() % 4 + 2;
        iWait = 1'b1;
        tick();
        waitMValid();
        armRedirect(mPc + 32'd4, target);
        branchM = 1'b1;
        branchTarget = target;
        tick();
        branchM = 1'b0;
        checkAddr("fetchPc", fetchPc, target);
        repeat (len) tick();
        iWait = 1'b0;
        waitRetire(10);
        checkValid("redirectArmed", redirectArmed, 1'b0);
    endtask

    task automatic excpInM(addrT vector);
        addrT faultPc;
        writeTrapVector(vector);
        waitMValid();
        faultPc = mPc;
        // The M token still retires ahead of the handler
        armRedirect(faultPc + 32'd4, vector);
        excpM = 1'b1;
        tick();
        excpM = 1'b0;
        checkAddr("epc", epc, faultPc);
        checkAddr("fetchPc", fetchPc, vector);
        waitRetire(10);
        checkValid("redirectArmed", redirectArmed, 1'b0);
    endtask

    task automatic excpInW(addrT vector);
        addrT faultPc;
        writeTrapVector(vector);
        while (!retireValid) begin
            tick();
        end
        faultPc = expectedPc;
        checkAddr("retirePc", retirePc, faultPc);
        // The W token itself never retires
        armRedirect(faultPc, vector);
        excpW = 1'b1;
        #5;
        checkValid("retireValid", retireValid, 1'b0);
        tick();
        excpW = 1'b0;
        checkAddr("epc", epc, faultPc);
        checkAddr("fetchPc", fetchPc, vector);
        waitRetire(10);
        checkValid("redirectArmed", redirectArmed, 1'b0);
    endtask

    initial begin
        reset = 1'b1;
        iWait = 1'b0;
        dWait = 1'b0;
        eWait = 1'b0;
        branchM = 1'b0;
        excpM = 1'b0;
        excpW = 1'b0;
        cfgWrite = 1'b0;
        branchTarget = '0;
        cfgVector = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        sequentialRetire();
        stallPulses();
        branchInM(32'h0000_2000);
        branchInIWait(32'h0000_3000);
        excpInM(32'h0000_0800);
        excpInW(32'h0000_0c00);

        $display("Everything OK");
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/pipePkg.sv
common/pipeCtrlIf.sv
hazard/hazard.sv
source/fetchPc.sv
source/trapRegs.sv
source/stageChain.sv
source/issueQueue.sv
source/pipeTop.sv
verif/pipeTb.sv

/* Bender.yml */
package:
  name: pipe_ctrl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pipePkg.sv
      - common/pipeCtrlIf.sv
      - hazard/hazard.sv
      - source/fetchPc.sv
      - source/trapRegs.sv
      - source/stageChain.sv
      - source/issueQueue.sv
      - source/pipeTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/pipeTb.sv
